// File: hw/aesTypesPkg.sv
`default_nettype none

package aesTypesPkg;

    typedef logic [7:0] byteT;

    // first byte of a word sits in the top bits.
    typedef logic [31:0] wordT;

    // one AES state. Column 0 and byte 0 are the most significant.
    typedef union packed {
        wordT [0:3]  cols;   // for MixColumns and AddRoundKey.
        byteT [0:15] bytes;  // for SubBytes and ShiftRows.
    } blockT;

    // expanded key, word 0 in the lowest bits.
    typedef wordT [43:0] keyScheduleT;

    typedef logic [3:0] roundIndexT;

endpackage

`default_nettype wire

// File: hw/aesFieldPkg.sv
`default_nettype none

package aesFieldPkg;

    localparam int numRounds = 10;
    localparam int lastRound = numRounds;

    // x^8 + x^4 + x^3 + x + 1 with the top bit dropped.
    localparam logic [7:0] fieldReduce = 8'h1b;
    localparam logic [7:0] affineConst = 8'h63;

    // multiply by x.
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? fieldReduce : 8'h00);
    endfunction

    // shift-and-add multiply.
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] term;
        acc = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc = acc ^ term;
            end
            term = xtime(term);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// File: hw/sBox.sv
`default_nettype none

module sBox
    import aesFieldPkg::*;
(
    input  logic [7:0] inByte,
    output logic [7:0] outByte
);

    // a^254 is the inverse of a in GF(2^8), and 0 stays 0.
    localparam logic [7:0] invExp = 8'd254;

    logic [7:0] inverse;
    logic [7:0] affine;

    always_comb
    begin : invPower
        logic [7:0] power;
        power = 8'h01;
        // left to right over the exponent bits.
        for (int i = 7; i >= 0; i--)
        begin
            power = gfMul(power, power);
            if (invExp[i])
            begin
                power = gfMul(power, inByte);
            end
        end
        inverse = power;
    end

    // bit i takes bits i, i+4, i+5, i+6 and i+7 of the inverse, modulo 8.
    always_comb
    begin : affineMap
        logic [7:0] mixed;
        mixed = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            mixed[i] = inverse[i]
                     ^ inverse[(i + 4) % 8]
                     ^ inverse[(i + 5) % 8]
                     ^ inverse[(i + 6) % 8]
                     ^ inverse[(i + 7) % 8];
        end
        affine = mixed;
    end

    assign outByte = affine ^ affineConst;  // constant added last.

endmodule

`default_nettype wire

// File: hw/mixColumn.sv
`default_nettype none

module mixColumn
    import aesTypesPkg::*;
    import aesFieldPkg::*;
(
    input  wordT inColumn,
    output wordT outColumn
);

    byteT a0, a1, a2, a3;
    byteT d0, d1, d2, d3;

    assign a0 = inColumn[31:24];  // row 0.
    assign a1 = inColumn[23:16];
    assign a2 = inColumn[15:8];
    assign a3 = inColumn[7:0];

    assign d0 = xtime(a0);
    assign d1 = xtime(a1);
    assign d2 = xtime(a2);
    assign d3 = xtime(a3);

    // coefficients 2 3 1 1, rotated one place per row. 3a is 2a ^ a.
    assign outColumn[31:24] = d0 ^ (d1 ^ a1) ^ a2 ^ a3;
    assign outColumn[23:16] = a0 ^ d1 ^ (d2 ^ a2) ^ a3;
    assign outColumn[15:8]  = a0 ^ a1 ^ d2 ^ (d3 ^ a3);
    assign outColumn[7:0]   = (d0 ^ a0) ^ a1 ^ a2 ^ d3;

endmodule

`default_nettype wire

// File: hw/roundSequencer.sv
`default_nettype none

module roundSequencer
    import aesTypesPkg::*;
    import aesFieldPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    input  keyScheduleT keySchedule,
    output logic        load,
    output logic        finalRound,
    output logic        finish,
    output logic        outValid,
    output blockT       roundKey
);

    logic       busy;
    roundIndexT round;  // stays 0 while idle, so it also selects the first key.
    logic [5:0] keyBase;

    assign load       = !busy && inValid;
    assign finalRound = busy && (round == roundIndexT'(lastRound));
    assign finish     = finalRound && inValid;  // no result on an aborted run.

    assign keyBase = {round, 2'b00};

    // round r uses key words 4r to 4r+3, the lowest going to column 0.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            roundKey.cols[c] = keySchedule[keyBase + 6'(c)];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            round    <= '0;
            outValid <= 1'b0;
        end
        else
        begin
            outValid <= finish;
            if (load)
            begin
                busy  <= 1'b1;
                round <= roundIndexT'(1);
            end
            else if (!inValid || finish)
            begin
                // done or aborted. A held inValid restarts on the next edge.
                busy  <= 1'b0;
                round <= '0;
            end
            else if (busy)
            begin
                round <= round + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/roundDatapath.sv
`default_nettype none

module roundDatapath
    import aesTypesPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  blockT msg,
    input  blockT roundKey,
    input  logic  load,
    input  logic  finalRound,
    input  logic  finish,
    output blockT cipher
);

    blockT stateQ;
    blockT cipherQ;
    blockT shifted;
    blockT roundOut;

    byteT subOut [16];
    wordT mixOut [4];

    genvar i;

    // SubBytes on every byte of the current state.
    generate
        for (i = 0; i < 16; i++)
        begin : genSub
            sBox u_sBox (
                .inByte  (stateQ.bytes[i]),
                .outByte (subOut[i])
            );
        end
    endgenerate

    // row r rotates left by r columns.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted.bytes[4 * c + r] = subOut[4 * ((c + r) % 4) + r];
            end
        end
    end

    generate
        for (i = 0; i < 4; i++)
        begin : genMix
            mixColumn u_mixColumn (
                .inColumn  (shifted.cols[i]),
                .outColumn (mixOut[i])
            );
        end
    endgenerate

    // round 10 has no MixColumns.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            if (finalRound)
            begin
                roundOut.cols[c] = shifted.cols[c] ^ roundKey.cols[c];
            end
            else
            begin
                roundOut.cols[c] = mixOut[c] ^ roundKey.cols[c];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stateQ  <= '0;
            cipherQ <= '0;
        end
        else if (load)
        begin
            stateQ <= msg ^ roundKey;  // initial key addition.
        end
        else if (finish)
        begin
            cipherQ <= roundOut;
        end
        else
        begin
            stateQ <= roundOut;
        end
    end

    assign cipher = cipherQ;

endmodule

`default_nettype wire

// File: hw/aesEncrypt.sv
`default_nettype none

module aesEncrypt
    import aesTypesPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  blockT       msg,
    input  keyScheduleT keySchedule,
    input  logic        inValid,
    output logic        outValid,
    output blockT       cipher
);

    logic  load;
    logic  finalRound;
    logic  finish;
    blockT roundKey;

    // decides load, round and finish, and picks the key words.
    roundSequencer i_roundSequencer (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .keySchedule (keySchedule),
        .load        (load),
        .finalRound  (finalRound),
        .finish      (finish),
        .outValid    (outValid),
        .roundKey    (roundKey)
    );

    // one full round per cycle, result held in the cipher register.
    roundDatapath i_roundDatapath (
        .clk        (clk),
        .reset      (reset),
        .msg        (msg),
        .roundKey   (roundKey),
        .load       (load),
        .finalRound (finalRound),
        .finish     (finish),
        .cipher     (cipher)
    );

endmodule

`default_nettype wire

// File: bench/aesModel.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// product of two bytes modulo x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] fieldMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;
    x = a;
    y = b;
    p = 8'h00;
    while (y != 8'h00)
    begin
        if (y[0])
        begin
            p = p ^ x;
        end
        x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
        y = y >> 1;
    end
    return p;
endfunction

// inverse found by search, then the affine step as a sum of rotations.
function automatic logic [7:0] subByte(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h00;
    for (int b = 1; b < 256; b++)
    begin
        if (fieldMul(a, 8'(b)) == 8'h01)
        begin
            inv = 8'(b);
        end
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic keyScheduleT expandKey(input logic [127:0] key);
    wordT w [44];
    wordT temp;
    logic [7:0] rcon;
    keyScheduleT sched;
    rcon = 8'h01;
    for (int i = 0; i < 44; i++)
    begin
        if (i < 4)
        begin
            w[i] = key[127 - 32 * i -: 32];
        end
        else
        begin
            temp = w[i - 1];
            if (i % 4 == 0)
            begin
                temp = {temp[23:0], temp[31:24]};  // RotWord.
                temp = {subByte(temp[31:24]) ^ rcon, subByte(temp[23:16]),
                        subByte(temp[15:8]), subByte(temp[7:0])};
                rcon = fieldMul(rcon, 8'h02);
            end
            w[i] = w[i - 4] ^ temp;
        end
        sched[i] = w[i];
    end
    return sched;
endfunction

// state byte 4c+r holds row r of column c.
function automatic logic [127:0] encryptBlock(input keyScheduleT sched,
                                              input logic [127:0] plain);
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [127:0] result;
    wordT kw;
    for (int i = 0; i < 16; i++)
    begin
        s[i] = plain[127 - 8 * i -: 8];
    end
    for (int rnd = 0; rnd <= 10; rnd++)
    begin
        if (rnd > 0)
        begin
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    t[4 * c + r] = subByte(s[4 * ((c + r) % 4) + r]);  // row r moves left r.
                end
            end
            for (int c = 0; c < 4; c++)
            begin
                for (int r = 0; r < 4; r++)
                begin
                    if (rnd < 10)
                    begin
                        s[4 * c + r] = fieldMul(8'h02, t[4 * c + r])
                                     ^ fieldMul(8'h03, t[4 * c + (r + 1) % 4])
                                     ^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
                    end
                    else
                    begin
                        s[4 * c + r] = t[4 * c + r];
                    end
                end
            end
        end
        for (int c = 0; c < 4; c++)
        begin
            kw = sched[4 * rnd + c];
            for (int r = 0; r < 4; r++)
            begin
                s[4 * c + r] = s[4 * c + r] ^ kw[31 - 8 * r -: 8];
            end
        end
    end
    for (int i = 0; i < 16; i++)
    begin
        result[127 - 8 * i -: 8] = s[i];
    end
    return result;
endfunction

`endif

// File: bench/aesEncryptTb.sv
`default_nettype none

module aesEncryptTb
    import aesTypesPkg::*;
    import aesFieldPkg::*;
();

    localparam int resultTimeout = 40;
    localparam int resultLatency = numRounds + 1;  // start edge to first high sample.

    logic        clk;
    logic        reset;
    blockT       msg;
    keyScheduleT keySchedule;
    logic        inValid;
    logic        outValid;
    blockT       cipher;

    int passCount;
    int failCount;
    logic [127:0] lastResult;

    `include "aesModel.svh"

    aesEncrypt i_aesEncrypt (
        .clk         (clk),
        .reset       (reset),
        .msg         (msg),
        .keySchedule (keySchedule),
        .inValid     (inValid),
        .outValid    (outValid),
        .cipher      (cipher)
    );

    always #2 clk = ~clk;

    task automatic stepCycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic checkBlock(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
        assert (actual === expected)
        begin
            passCount++;
        end
        else
        begin
            failCount++;
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic checkNumber(input string what, input int expected, input int actual);
        assert (actual == expected)
        begin
            passCount++;
        end
        else
        begin
            failCount++;
            $display("[ERROR] %0t: %s expected %0d, got %0d", $time, what, expected, actual);
        end
    endtask

    // counts rising edges until outValid is seen at a falling edge.
    task automatic waitForResult(output int cycles);
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < resultTimeout)
        begin
            stepCycle();
            cycles++;
            seen = outValid;
        end
        if (!seen)
        begin
            failCount++;
            $display("timeout: no result within %0d cycles at time %0t", resultTimeout, $time);
        end
    endtask

    task automatic reportTest(input string name, input int failsBefore);
        $display("%s: %s", name, (failCount == failsBefore) ? "ok" : "failed");
    endtask

    function automatic logic [127:0] randomBlock();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic resetTest();
        int fails;
        fails = failCount;
        for (int k = 0; k < 8; k++)
        begin
            @(negedge clk);
            reset = (k < 4);  // released after the fifth rising edge.
            checkNumber("outValid after reset", 0, int'(outValid));
            checkBlock("cipher after reset", '0, cipher);
        end
        reportTest("reset state", fails);
    endtask

    task automatic knownAnswerTest();
        logic [127:0] key;
        logic [127:0] plain;
        logic [127:0] expected;
        int fails;
        int cycles;
        fails = failCount;
        key = 128'h000102030405060708090a0b0c0d0e0f;
        plain = 128'h00112233445566778899aabbccddeeff;
        expected = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        checkBlock("model known answer", expected, encryptBlock(expandKey(key), plain));
        keySchedule = expandKey(key);
        msg = plain;
        inValid = 1'b1;
        waitForResult(cycles);
        checkNumber("known answer latency", resultLatency, cycles);
        checkBlock("known answer cipher", expected, cipher);
        inValid = 1'b0;
        stepCycle();
        checkNumber("outValid pulse width", 0, int'(outValid));
        lastResult = expected;
        reportTest("known answer", fails);
    endtask

    task automatic randomTest();
        logic [127:0] key;
        logic [127:0] plain;
        int fails;
        int cycles;
        fails = failCount;
        for (int n = 0; n < 20; n++)
        begin
            key = randomBlock();
            plain = randomBlock();
            keySchedule = expandKey(key);
            msg = plain;
            inValid = 1'b1;
            waitForResult(cycles);
            lastResult = encryptBlock(expandKey(key), plain);
            checkBlock("random cipher", lastResult, cipher);
            inValid = 1'b0;
            stepCycle();
            checkNumber("outValid between runs", 0, int'(outValid));
        end
        reportTest("random blocks", fails);
    endtask

    // msg changes mid-run. Each block must use the value at its own start edge.
    task automatic heldValidTest();
        logic [127:0] blocks [4];
        keyScheduleT sched;
        int fails;
        int cycles;
        fails = failCount;
        sched = expandKey(randomBlock());
        for (int b = 0; b < 4; b++)
        begin
            blocks[b] = randomBlock();
        end
        keySchedule = sched;
        msg = blocks[0];
        inValid = 1'b1;
        for (int b = 0; b < 3; b++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                stepCycle();
                checkNumber("outValid early in run", 0, int'(outValid));
            end
            msg = blocks[b + 1];
            waitForResult(cycles);
            checkNumber("result spacing", resultLatency, cycles + 5);
            lastResult = encryptBlock(sched, blocks[b]);
            checkBlock("held inValid cipher", lastResult, cipher);
        end
        inValid = 1'b0;
        stepCycle();
        checkNumber("outValid after held runs", 0, int'(outValid));
        reportTest("held inValid", fails);
    endtask

    task automatic abortTest();
        logic [127:0] plain;
        int fails;
        int cycles;
        fails = failCount;
        keySchedule = expandKey(randomBlock());
        msg = randomBlock();
        inValid = 1'b1;
        for (int k = 0; k < 6; k++)
        begin
            stepCycle();  // load edge and rounds 1 to 5.
        end
        inValid = 1'b0;
        for (int k = 0; k < 20; k++)
        begin
            stepCycle();
            checkNumber("outValid after abort", 0, int'(outValid));
        end
        checkBlock("cipher after abort", lastResult, cipher);
        // the next run has to start from idle with the first round key.
        plain = randomBlock();
        msg = plain;
        inValid = 1'b1;
        waitForResult(cycles);
        checkNumber("latency after abort", resultLatency, cycles);
        lastResult = encryptBlock(keySchedule, plain);
        checkBlock("cipher of run after abort", lastResult, cipher);
        inValid = 1'b0;
        stepCycle();
        reportTest("abort", fails);
    endtask

    initial
    begin
        void'($urandom(32'h920d_13a2));
        clk = 1'b0;
        reset = 1'b1;
        inValid = 1'b0;
        msg = '0;
        keySchedule = '0;
        passCount = 0;
        failCount = 0;
        lastResult = '0;
        resetTest();
        knownAnswerTest();
        randomTest();
        heldValidTest();
        abortTest();
        $display("checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+bench
hw/aesTypesPkg.sv
hw/aesFieldPkg.sv
hw/sBox.sv
hw/mixColumn.sv
hw/roundSequencer.sv
hw/roundDatapath.sv
hw/aesEncrypt.sv
bench/aesEncryptTb.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal -f files.f --top-module aesEncryptTb -o aesSim \
    && ./obj_dir/aesSim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: build or simulation failed"; exit 1; }
